/* Makefile */
# Verilator build and run of the management register testbench

VERILATOR ?= verilator
TOP       ?= tb_mgmt_regs
FILELIST  ?= mgmt_regs.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail, not the exit code of the simulator
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/bert_lane_config.sv */
`timescale 1ns/100ps
`default_nettype none

module bert_lane_config import mgmt_pkg::*; #(
	parameter int lane_index = 0
) (
	input wire             clk,
	input wire             reset,

	//Host write port
	input wire mgmt_wr_t   wr,

	//Serdes settings for this lane
	output bert_txconfig_t tx_config,
	output bert_rxconfig_t rx_config,
	output logic           config_updated
);

	////////////////////////////////////////////////////////////
	// Write decode

	logic     wr_hit;
	reg_off_t wr_off;
	logic     strobe_wr;

	assign wr_hit = wr.en && lane_hit(wr.addr, lane_index);
	assign wr_off = lane_off(wr.addr, lane_index);

	//Registers that notify the serdes side
	//off_tx is the low half of the tx word, so it waits for off_tx_1
	always_comb begin
		strobe_wr = 1'b0;
		if (wr_hit) begin
			case (wr_off)
				off_prbs, off_tx_1, off_clk, off_rst, off_rx: strobe_wr = 1'b1;
				default: strobe_wr = 1'b0;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Configuration registers

	always_ff @(posedge clk) begin
		if (reset) begin
			tx_config      <= '0;
			rx_config      <= '0;
			config_updated <= 1'b0;
		end else begin
			//Strobe in the cycle after a notifying write
			config_updated <= strobe_wr;

			if (wr_hit) begin
				case (wr_off)
					off_prbs: begin
						rx_config.prbsmode <= wr.data[2:0];
						tx_config.prbsmode <= wr.data[6:4];
					end

					//Swing plus low bits of precursor
					off_tx: begin
						tx_config.swing          <= wr.data[3:0];
						tx_config.precursor[3:0] <= wr.data[7:4];
					end
					off_tx_1: begin
						tx_config.precursor[4] <= wr.data[0];
						tx_config.postcursor   <= wr.data[5:1];
						tx_config.enable       <= wr.data[6];
						tx_config.invert       <= wr.data[7];
					end

					//Clock dividers and PLL select, both directions
					off_clk: begin
						tx_config.clkdiv        <= wr.data[2:0];
						tx_config.clk_from_qpll <= wr.data[3];
						rx_config.clkdiv        <= wr.data[6:4];
						rx_config.clk_from_qpll <= wr.data[7];
					end

					//Soft resets
					off_rst: begin
						rx_config.pmareset <= wr.data[0];
						tx_config.tx_reset <= wr.data[1];
						rx_config.rx_reset <= wr.data[2];
					end

					off_rx: rx_config.invert <= wr.data[0];

					default: begin
					end
				endcase
			end
		end
	end

	//Serdes side samples on an edge of the strobe
	assert property (@(posedge clk) disable iff (reset) config_updated |=> !config_updated)
		else $error("lane %0d config_updated high for two cycles", lane_index);

endmodule

`default_nettype wire

/* hw/drp_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

module drp_bridge import mgmt_pkg::*; #(
	parameter int lane_index = 0
) (
	input wire           clk,
	input wire           reset,

	//Host write port
	input wire mgmt_wr_t wr,

	//DRP port of this lane
	output logic         drp_en,
	output drp_req_t     drp_req,
	input wire           drp_done,
	input wire drp_data_t drp_rdata,

	//Lane state for the read path
	input wire           rx_rstdone,
	output lane_status_t status
);

	////////////////////////////////////////////////////////////
	// Write decode

	logic       wr_hit;
	reg_off_t   wr_off;
	logic       issue;
	drp_data_t  wdata_stage;
	mgmt_data_t addr_stage;
	logic       busy;
	drp_data_t  rdata;

	assign wr_hit = wr.en && lane_hit(wr.addr, lane_index);
	assign wr_off = lane_off(wr.addr, lane_index);

	//Command goes out only on an idle lane
	//drp_en covers the cycle before busy rises
	assign issue = wr_hit && (wr_off == off_ad_1) && !busy && !drp_en;

	////////////////////////////////////////////////////////////
	// Command staging

	always_ff @(posedge clk) begin
		if (wr_hit) begin
			case (wr_off)
				off_wd:   wdata_stage[7:0]  <= wr.data;
				off_wd_1: wdata_stage[15:8] <= wr.data;
				off_ad:   addr_stage        <= wr.data;
				default: begin
				end
			endcase
		end

		//Request held until the next accepted command
		if (issue) begin
			drp_req.we    <= wr.data[7];
			drp_req.addr  <= {wr.data[0], addr_stage};
			drp_req.wdata <= wdata_stage;
		end
	end

	////////////////////////////////////////////////////////////
	// Handshake and busy tracking

	always_ff @(posedge clk) begin
		if (reset) begin
			drp_en <= 1'b0;
			busy   <= 1'b0;
			rdata  <= '0;
		end else begin
			drp_en <= issue;

			//Busy from the cycle after enable to the cycle after done
			if (drp_en)
				busy <= 1'b1;
			if (drp_done) begin
				busy <= 1'b0;

				//Keep the last read word, writes return nothing useful
				if (!drp_req.we)
					rdata <= drp_rdata;
			end
		end
	end

	assign status.rdata      = rdata;
	assign status.busy       = busy;
	assign status.rx_rstdone = rx_rstdone;

	////////////////////////////////////////////////////////////
	// Protocol checks

	//Transceiver answers only an outstanding access
	assert property (@(posedge clk) disable iff (reset) drp_done |-> busy)
		else $error("lane %0d drp_done with no access open", lane_index);

	//one access at a time per lane
	assert property (@(posedge clk) disable iff (reset) drp_en |-> !busy)
		else $error("lane %0d drp_en while busy", lane_index);

endmodule

`default_nettype wire

/* hw/mgmt_pkg.sv */
`default_nettype none

package mgmt_pkg;

	////////////////////////////////////////////////////////////
	// Widths

	//Host register bus
	typedef logic [15:0] mgmt_addr_t;
	typedef logic [7:0]  mgmt_data_t;

	//Register offset inside one lane window
	typedef logic [7:0]  reg_off_t;

	//Transceiver DRP port
	typedef logic [8:0]  drp_addr_t;
	typedef logic [15:0] drp_data_t;

	//Serdes fields
	typedef logic [2:0]  prbs_mode_t;
	typedef logic [2:0]  clk_div_t;
	typedef logic [4:0]  tap_t;
	typedef logic [3:0]  swing_t;

	////////////////////////////////////////////////////////////
	// Register map

	localparam int         num_lanes   = 2;
	localparam mgmt_addr_t lane_base   = 16'h0080;
	localparam mgmt_addr_t lane_stride = 16'h0020;

	//Offsets within a lane window
	localparam reg_off_t off_prbs = 8'h00;
	localparam reg_off_t off_tx   = 8'h02;
	localparam reg_off_t off_tx_1 = 8'h03;
	localparam reg_off_t off_wd   = 8'h04;
	localparam reg_off_t off_wd_1 = 8'h05;
	localparam reg_off_t off_ad   = 8'h06;
	localparam reg_off_t off_ad_1 = 8'h07;	//write issues the DRP command
	localparam reg_off_t off_rd   = 8'h08;
	localparam reg_off_t off_rd_1 = 8'h09;
	localparam reg_off_t off_stat = 8'h0a;
	localparam reg_off_t off_clk  = 8'h0c;
	localparam reg_off_t off_rst  = 8'h0e;
	localparam reg_off_t off_rx   = 8'h10;

	////////////////////////////////////////////////////////////
	// Bundles

	typedef struct packed {
		logic       en;
		mgmt_addr_t addr;
		mgmt_data_t data;
	} mgmt_wr_t;

	typedef struct packed {
		prbs_mode_t prbsmode;
		swing_t     swing;
		tap_t       precursor;
		tap_t       postcursor;
		logic       enable;
		logic       invert;
		clk_div_t   clkdiv;
		logic       clk_from_qpll;	//0 selects the CPLL
		logic       tx_reset;
	} bert_txconfig_t;

	typedef struct packed {
		prbs_mode_t prbsmode;
		logic       invert;
		clk_div_t   clkdiv;
		logic       clk_from_qpll;
		logic       pmareset;
		logic       rx_reset;
	} bert_rxconfig_t;

	typedef struct packed {
		logic      we;
		drp_addr_t addr;
		drp_data_t wdata;
	} drp_req_t;

	typedef struct packed {
		drp_data_t rdata;
		logic      busy;
		logic      rx_rstdone;
	} lane_status_t;

	////////////////////////////////////////////////////////////
	// Lane window decode

	//First address of a lane
	function automatic mgmt_addr_t lane_start(input int lane);
		return lane_base + mgmt_addr_t'(lane) * lane_stride;
	endfunction

	//Address falls inside the window of this lane
	function automatic logic lane_hit(input mgmt_addr_t addr, input int lane);
		return (addr >= lane_start(lane)) && ((addr - lane_start(lane)) < lane_stride);
	endfunction

	//Offset relative to the lane base, only meaningful on a hit
	function automatic reg_off_t lane_off(input mgmt_addr_t addr, input int lane);
		mgmt_addr_t rel;
		rel = addr - lane_start(lane);
		return rel[7:0];
	endfunction

endpackage

`default_nettype wire

/* hw/mgmt_read_mux.sv */
`timescale 1ns/100ps
`default_nettype none

module mgmt_read_mux import mgmt_pkg::*; (
	input wire               clk,
	input wire               reset,

	//Host read request
	input wire               rd_en,
	input wire mgmt_addr_t   rd_addr,

	//Per-lane DRP data and status
	input wire lane_status_t lane0_status,
	input wire lane_status_t lane1_status,

	//Read response, one cycle after the request
	output logic             rd_valid,
	output mgmt_data_t       rd_data
);

	lane_status_t lane_status [num_lanes];
	mgmt_data_t   rd_byte;

	assign lane_status[0] = lane0_status;
	assign lane_status[1] = lane1_status;

	////////////////////////////////////////////////////////////
	// Address decode

	//Config registers are write only and fall to the zero default
	always_comb begin
		rd_byte = '0;
		for (int i = 0; i < num_lanes; i++) begin
			if (lane_hit(rd_addr, i)) begin
				case (lane_off(rd_addr, i))
					off_rd:   rd_byte = lane_status[i].rdata[7:0];
					off_rd_1: rd_byte = lane_status[i].rdata[15:8];
					off_stat: rd_byte = {6'b0, lane_status[i].rx_rstdone, lane_status[i].busy};
					default:  rd_byte = '0;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Response register

	always_ff @(posedge clk) begin
		if (reset)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_en;
	end

	//Data only moves on a request
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= rd_byte;
	end

	//Fixed single cycle latency, back to back included
	assert property (@(posedge clk) disable iff (reset) rd_en |=> rd_valid)
		else $error("rd_valid missing after rd_en");

endmodule

`default_nettype wire

/* hw/mgmt_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module mgmt_regs import mgmt_pkg::*; (
	input wire             clk,
	input wire             reset,

	//Host register bus
	input wire mgmt_wr_t   wr,
	input wire             rd_en,
	input wire mgmt_addr_t rd_addr,
	output logic           rd_valid,
	output mgmt_data_t     rd_data,

	//Serdes configuration
	output bert_txconfig_t tx0_config,
	output bert_txconfig_t tx1_config,
	output bert_rxconfig_t rx0_config,
	output bert_rxconfig_t rx1_config,
	output logic           config0_updated,
	output logic           config1_updated,

	//DRP ports, one per lane
	output logic           drp0_en,
	output logic           drp1_en,
	output drp_req_t       drp0_req,
	output drp_req_t       drp1_req,
	input wire             drp0_done,
	input wire             drp1_done,
	input wire drp_data_t  drp0_rdata,
	input wire drp_data_t  drp1_rdata,

	//Receiver reset done from each lane
	input wire             rx0_rstdone,
	input wire             rx1_rstdone
);

	lane_status_t lane0_status;
	lane_status_t lane1_status;

	////////////////////////////////////////////////////////////
	// Lane 0

	bert_lane_config #(
		.lane_index(0)
	) i_lane0_config (
		.clk            (clk),
		.reset          (reset),
		.wr             (wr),
		.tx_config      (tx0_config),
		.rx_config      (rx0_config),
		.config_updated (config0_updated)
	);

	drp_bridge #(
		.lane_index(0)
	) i_lane0_drp (
		.clk        (clk),
		.reset      (reset),
		.wr         (wr),
		.drp_en     (drp0_en),
		.drp_req    (drp0_req),
		.drp_done   (drp0_done),
		.drp_rdata  (drp0_rdata),
		.rx_rstdone (rx0_rstdone),
		.status     (lane0_status)
	);

	////////////////////////////////////////////////////////////
	// Lane 1

	bert_lane_config #(
		.lane_index(1)
	) i_lane1_config (
		.clk            (clk),
		.reset          (reset),
		.wr             (wr),
		.tx_config      (tx1_config),
		.rx_config      (rx1_config),
		.config_updated (config1_updated)
	);

	drp_bridge #(
		.lane_index(1)
	) i_lane1_drp (
		.clk        (clk),
		.reset      (reset),
		.wr         (wr),
		.drp_en     (drp1_en),
		.drp_req    (drp1_req),
		.drp_done   (drp1_done),
		.drp_rdata  (drp1_rdata),
		.rx_rstdone (rx1_rstdone),
		.status     (lane1_status)
	);

	////////////////////////////////////////////////////////////
	// Read path

	mgmt_read_mux i_read_mux (
		.clk          (clk),
		.reset        (reset),
		.rd_en        (rd_en),
		.rd_addr      (rd_addr),
		.lane0_status (lane0_status),
		.lane1_status (lane1_status),
		.rd_valid     (rd_valid),
		.rd_data      (rd_data)
	);

endmodule

`default_nettype wire

/* mgmt_regs.f */
hw/mgmt_pkg.sv
hw/bert_lane_config.sv
hw/drp_bridge.sv
hw/mgmt_read_mux.sv
hw/mgmt_regs.sv
test/tb_drp_model.sv
test/tb_mgmt_regs.sv

/* test/tb_drp_model.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_drp_model import mgmt_pkg::*; #(
	parameter int lane_index = 0
) (
	input wire           clk,
	input wire           reset,

	//DRP port as seen from the transceiver
	input wire           en,
	input wire drp_req_t req,
	output logic         done,
	output drp_data_t    rdata
);

	drp_data_t mem [512];
	drp_addr_t addr_q;
	drp_addr_t fill_addr;
	logic      active;
	int        delay;

	//Fill word carries the lane and the full address
	initial begin
		for (int i = 0; i < 512; i++) begin
			fill_addr = 9'(i);
			mem[fill_addr] = {7'h5a ^ 7'(lane_index), fill_addr};
		end
	end

	////////////////////////////////////////////////////////////
	// Responder, driven on the falling edge

	always @(negedge clk) begin
		if (reset) begin
			done   <= 1'b0;
			rdata  <= '0;
			active <= 1'b0;
			delay  <= 0;
		end else begin
			done <= 1'b0;
			if (en && !active) begin
				//Writes land at once, reads sample at done
				active <= 1'b1;
				addr_q <= req.addr;
				delay  <= 4 + int'($urandom % 5);
				if (req.we)
					mem[req.addr] <= req.wdata;
			end else if (active) begin
				if (delay <= 1) begin
					done   <= 1'b1;
					rdata  <= mem[addr_q];
					active <= 1'b0;
				end else begin
					delay <= delay - 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* test/tb_mgmt_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mgmt_regs import mgmt_pkg::*; ();

	logic           clk;
	logic           reset;
	mgmt_wr_t       wr;
	logic           rd_en;
	mgmt_addr_t     rd_addr;
	logic           rd_valid;
	mgmt_data_t     rd_data;
	bert_txconfig_t tx0_config;
	bert_txconfig_t tx1_config;
	bert_rxconfig_t rx0_config;
	bert_rxconfig_t rx1_config;
	logic           config0_updated;
	logic           config1_updated;
	logic           drp0_en;
	logic           drp1_en;
	drp_req_t       drp0_req;
	drp_req_t       drp1_req;
	logic           drp0_done;
	logic           drp1_done;
	drp_data_t      drp0_rdata;
	drp_data_t      drp1_rdata;
	logic           rx0_rstdone;
	logic           rx1_rstdone;

	//Shadow of the field map and the DRP side
	mgmt_data_t     regs [2][256];
	drp_data_t      drp_shadow [2][512];
	drp_data_t      last_rd [2];
	drp_req_t       exp_req [2];
	logic [1:0]     exp_upd;
	logic [1:0]     exp_en;
	logic [1:0]     exp_busy;
	logic [1:0]     cmd_open;
	logic [1:0]     done_v;
	logic           exp_valid;
	mgmt_data_t     exp_rd;
	bert_txconfig_t exp_tx0;
	bert_txconfig_t exp_tx1;
	bert_rxconfig_t exp_rx0;
	bert_rxconfig_t exp_rx1;

	int             errors;
	int             errors_before;
	int             tests;
	int unsigned    seed_val;
	drp_addr_t      test_addr [2];
	mgmt_data_t     stat;
	mgmt_data_t     rd_byte;
	reg_off_t       cfg_offs [6];

	mgmt_regs i_mgmt_regs (.*);

	tb_drp_model #(.lane_index(0)) i_drp0 (
		.clk   (clk),
		.reset (reset),
		.en    (drp0_en),
		.req   (drp0_req),
		.done  (drp0_done),
		.rdata (drp0_rdata)
	);

	tb_drp_model #(.lane_index(1)) i_drp1 (
		.clk   (clk),
		.reset (reset),
		.en    (drp1_en),
		.req   (drp1_req),
		.done  (drp1_done),
		.rdata (drp1_rdata)
	);

	always #5 clk = ~clk;

	assign done_v = {drp1_done, drp0_done};

	////////////////////////////////////////////////////////////
	// Expected values from the field map

	function automatic bert_txconfig_t tx_expect(input mgmt_data_t prbs, input mgmt_data_t tx,
		input mgmt_data_t tx_1, input mgmt_data_t clks, input mgmt_data_t rst);
		bert_txconfig_t t;
		t.prbsmode      = prbs[6:4];
		t.swing         = tx[3:0];
		t.precursor     = {tx_1[0], tx[7:4]};
		t.postcursor    = tx_1[5:1];
		t.enable        = tx_1[6];
		t.invert        = tx_1[7];
		t.clkdiv        = clks[2:0];
		t.clk_from_qpll = clks[3];
		t.tx_reset      = rst[1];
		return t;
	endfunction

	function automatic bert_rxconfig_t rx_expect(input mgmt_data_t prbs, input mgmt_data_t clks,
		input mgmt_data_t rst, input mgmt_data_t rx);
		bert_rxconfig_t r;
		r.prbsmode      = prbs[2:0];
		r.invert        = rx[0];
		r.clkdiv        = clks[6:4];
		r.clk_from_qpll = clks[7];
		r.pmareset      = rst[0];
		r.rx_reset      = rst[2];
		return r;
	endfunction

	assign exp_tx0 = tx_expect(regs[0][off_prbs], regs[0][off_tx], regs[0][off_tx_1],
		regs[0][off_clk], regs[0][off_rst]);
	assign exp_tx1 = tx_expect(regs[1][off_prbs], regs[1][off_tx], regs[1][off_tx_1],
		regs[1][off_clk], regs[1][off_rst]);
	assign exp_rx0 = rx_expect(regs[0][off_prbs], regs[0][off_clk], regs[0][off_rst],
		regs[0][off_rx]);
	assign exp_rx1 = rx_expect(regs[1][off_prbs], regs[1][off_clk], regs[1][off_rst],
		regs[1][off_rx]);

	//Byte a read returns, from the state at the request edge
	function automatic mgmt_data_t read_expect(input mgmt_addr_t addr);
		mgmt_addr_t rel;
		logic       ln;
		logic [1:0] st;
		rel = addr - lane_base;
		ln  = rel[5];
		if (addr < lane_base || rel >= 16'h0040)
			return '0;
		st = {ln ? rx1_rstdone : rx0_rstdone, exp_busy[ln]};
		case ({3'b000, rel[4:0]})
			off_rd:   return last_rd[ln][7:0];
			off_rd_1: return last_rd[ln][15:8];
			off_stat: return {6'b000000, st};
			default:  return '0;
		endcase
	endfunction

	//Mirror of the bus, one edge per host cycle
	always @(posedge clk) begin
		mgmt_addr_t rel;
		logic       hit;
		logic       wl;
		reg_off_t   wo;
		logic       ln;
		logic       take;
		rel = wr.addr - lane_base;
		hit = wr.en && (wr.addr >= lane_base) && (rel < 16'h0040);
		wl  = rel[5];
		wo  = {3'b000, rel[4:0]};
		exp_valid <= rd_en && !reset;
		if (rd_en)
			exp_rd <= read_expect(rd_addr);
		if (reset) begin
			regs     <= '{default: '{default: 8'h00}};
			exp_upd  <= '0;
			exp_en   <= '0;
			exp_busy <= '0;
			cmd_open <= '0;
			last_rd  <= '{default: 16'h0000};
		end else begin
			if (hit)
				regs[wl][wo] <= wr.data;
			for (int i = 0; i < num_lanes; i++) begin
				ln   = i[0];
				take = hit && (wl == ln) && (wo == off_ad_1) && !cmd_open[ln];
				exp_upd[ln] <= hit && (wl == ln) &&
					(wo inside {off_prbs, off_tx_1, off_clk, off_rst, off_rx});
				exp_en[ln] <= take;
				//One open command per lane, later ones dropped
				if (take) begin
					cmd_open[ln] <= 1'b1;
					exp_req[ln]  <= {wr.data[7], wr.data[0], regs[ln][off_ad],
						regs[ln][off_wd_1], regs[ln][off_wd]};
				end else if (done_v[ln]) begin
					cmd_open[ln] <= 1'b0;
				end
				if (exp_en[ln])
					exp_busy[ln] <= 1'b1;
				if (done_v[ln])
					exp_busy[ln] <= 1'b0;
				if (exp_en[ln] && exp_req[ln].we)
					drp_shadow[ln][exp_req[ln].addr] <= exp_req[ln].wdata;
				if (done_v[ln] && !exp_req[ln].we)
					last_rd[ln] <= drp_shadow[ln][exp_req[ln].addr];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Checks

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("FAILED %s expected %h got %h at %0t", name, expected, actual, $time);
		errors++;
	endtask

	//Outputs quiet from the edge after reset
	assert property (@(posedge clk) reset |=> (tx0_config == '0 && tx1_config == '0 &&
		rx0_config == '0 && rx1_config == '0 && !config0_updated && !config1_updated &&
		!drp0_en && !drp1_en && !rd_valid))
		else begin
			$display("Outputs not cleared by reset at %0t", $time);
			errors++;
		end

	assert property (@(posedge clk) disable iff (reset) tx0_config == exp_tx0)
		else report_mismatch("tx0_config", 32'(exp_tx0), 32'(tx0_config));
	assert property (@(posedge clk) disable iff (reset) tx1_config == exp_tx1)
		else report_mismatch("tx1_config", 32'(exp_tx1), 32'(tx1_config));
	assert property (@(posedge clk) disable iff (reset) rx0_config == exp_rx0)
		else report_mismatch("rx0_config", 32'(exp_rx0), 32'(rx0_config));
	assert property (@(posedge clk) disable iff (reset) rx1_config == exp_rx1)
		else report_mismatch("rx1_config", 32'(exp_rx1), 32'(rx1_config));

	//Strobes, including silence after off_tx
	assert property (@(posedge clk) disable iff (reset) config0_updated == exp_upd[0])
		else report_mismatch("config0_updated", 32'(exp_upd[0]), 32'(config0_updated));
	assert property (@(posedge clk) disable iff (reset) config1_updated == exp_upd[1])
		else report_mismatch("config1_updated", 32'(exp_upd[1]), 32'(config1_updated));

	//DRP enable pulse and its request
	assert property (@(posedge clk) disable iff (reset) drp0_en == exp_en[0])
		else report_mismatch("drp0_en", 32'(exp_en[0]), 32'(drp0_en));
	assert property (@(posedge clk) disable iff (reset) drp1_en == exp_en[1])
		else report_mismatch("drp1_en", 32'(exp_en[1]), 32'(drp1_en));
	assert property (@(posedge clk) disable iff (reset) drp0_en |-> drp0_req == exp_req[0])
		else report_mismatch("drp0_req", 32'(exp_req[0]), 32'(drp0_req));
	assert property (@(posedge clk) disable iff (reset) drp1_en |-> drp1_req == exp_req[1])
		else report_mismatch("drp1_req", 32'(exp_req[1]), 32'(drp1_req));

	//Read response
	assert property (@(posedge clk) disable iff (reset) rd_valid == exp_valid)
		else report_mismatch("rd_valid", 32'(exp_valid), 32'(rd_valid));
	assert property (@(posedge clk) disable iff (reset) rd_valid |-> rd_data == exp_rd)
		else report_mismatch("rd_data", 32'(exp_rd), 32'(rd_data));

	////////////////////////////////////////////////////////////
	// Host bus tasks

	function automatic mgmt_addr_t reg_addr(input logic lane, input reg_off_t off);
		return lane_base + (lane ? lane_stride : 16'h0000) + {8'h00, off};
	endfunction

	task automatic write_reg(input logic lane, input reg_off_t off, input mgmt_data_t data);
		@(negedge clk);
		wr.en   = 1'b1;
		wr.addr = reg_addr(lane, off);
		wr.data = data;
		@(negedge clk);
		wr.en = 1'b0;
	endtask

	task automatic read_reg(input logic lane, input reg_off_t off, output mgmt_data_t data);
		int wait_cycles;
		@(negedge clk);
		rd_en   = 1'b1;
		rd_addr = reg_addr(lane, off);
		@(negedge clk);
		rd_en       = 1'b0;
		wait_cycles = 0;
		while (!rd_valid && wait_cycles < 10) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (!rd_valid) begin
			$display("No read response for address %h", rd_addr);
			errors++;
		end
		data = rd_data;
	endtask

	//Staging writes, then the command byte
	task automatic drp_access(input logic lane, input logic we, input drp_addr_t addr,
		input drp_data_t wdata);
		write_reg(lane, off_wd, wdata[7:0]);
		write_reg(lane, off_wd_1, wdata[15:8]);
		write_reg(lane, off_ad, addr[7:0]);
		write_reg(lane, off_ad_1, {we, 6'b000000, addr[8]});
	endtask

	task automatic wait_idle(input logic lane);
		mgmt_data_t st;
		int         polls;
		polls = 0;
		st    = 8'h01;
		while (st[0] && polls < 50) begin
			read_reg(lane, off_stat, st);
			polls++;
		end
		if (st[0]) begin
			$display("Lane %0d DRP access still busy after %0d polls", lane, polls);
			errors++;
		end
	endtask

	//Reads on every cycle, mapped and unmapped
	task automatic read_sweep();
		mgmt_addr_t addrs [8];
		addrs = '{16'h0000, 16'h007f, reg_addr(1'b0, off_stat), reg_addr(1'b1, off_stat),
			reg_addr(1'b0, off_rd), reg_addr(1'b1, off_rd_1), reg_addr(1'b0, off_prbs),
			16'hffff};
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			rd_en   = 1'b1;
			rd_addr = addrs[i];
		end
		@(negedge clk);
		rd_en = 1'b0;
	endtask

	task automatic finish_test(input string name);
		repeat (2) @(negedge clk);
		tests++;
		$display("Test %0d %s done, %0d new errors", tests, name, errors - errors_before);
		errors_before = errors;
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		seed_val      = $urandom(32'hc791_e795);
		errors        = 0;
		errors_before = 0;
		tests         = 0;
		clk           = 1'b0;
		reset         = 1'b1;
		wr            = '0;
		rd_en         = 1'b0;
		rd_addr       = '0;
		rx0_rstdone   = 1'b0;
		rx1_rstdone   = 1'b0;
		cfg_offs      = '{off_prbs, off_tx, off_tx_1, off_clk, off_rst, off_rx};
		repeat (8) @(negedge clk);
		reset = 1'b0;
		finish_test("reset");

		//Random bytes into every config register of both lanes
		for (int round = 0; round < 4; round++) begin
			for (int l = 0; l < num_lanes; l++) begin
				for (int k = 0; k < 6; k++)
					write_reg(l[0], cfg_offs[k], 8'($urandom));
			end
		end
		finish_test("config fields");

		//Write command, then a second one while busy
		for (int l = 0; l < num_lanes; l++) begin
			test_addr[l] = 9'($urandom);
			drp_access(l[0], 1'b1, test_addr[l], 16'($urandom));
			read_reg(l[0], off_stat, stat);
			if (!stat[0]) begin
				$display("Lane %0d busy flag not set after a DRP command", l);
				errors++;
			end
			write_reg(l[0], off_ad_1, 8'h81);
			wait_idle(l[0]);
		end
		finish_test("DRP write");

		//Read back what the write left in the model
		for (int l = 0; l < num_lanes; l++) begin
			drp_access(l[0], 1'b0, test_addr[l], 16'h0000);
			wait_idle(l[0]);
			read_reg(l[0], off_rd, rd_byte);
			read_reg(l[0], off_rd_1, rd_byte);
		end
		finish_test("DRP read");

		//Back to back reads with the reset done inputs flipped
		@(negedge clk);
		rx0_rstdone = 1'b1;
		read_sweep();
		@(negedge clk);
		rx0_rstdone = 1'b0;
		rx1_rstdone = 1'b1;
		read_sweep();
		finish_test("read path");

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	//Watchdog for the whole run
	initial begin
		#1000000;
		$display("Simulation timed out with %0d errors", errors);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
